//--- verilog.f
design/host_domain_pkg.sv
design/l2_req_buffer.sv
design/l2_bank_arbiter.sv
design/l2_bank_array.sv
design/host_domain.sv
verif/tb_clock_gen.sv
verif/host_domain_checker.sv
verif/tb_host_domain.sv

//--- Bender.yml
package:
  name: host_domain

sources:
  - files:
      - design/host_domain_pkg.sv
      - design/l2_req_buffer.sv
      - design/l2_bank_arbiter.sv
      - design/l2_bank_array.sv
      - design/host_domain.sv

  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/host_domain_checker.sv
      - verif/tb_host_domain.sv

//--- verif/tb_host_domain.sv
// Reads only hit addresses 0..63, which the first two tests write; requests keep the two-clock spacing
module tb_host_domain;

  timeunit 1ns;
  timeprecision 1ps;

  typedef logic [host_domain_pkg::L2AddrWidth-1:0] addr_t;
  typedef logic [host_domain_pkg::L2DataWidth-1:0] data_t;
  typedef struct {
    logic [31:0] due;
    data_t       data;
    string       name;
  } exp_t;

  localparam int          ClkPeriodNs   = 8;
  localparam int          ResetCycles   = 5;
  localparam int          DriveDelay    = 1;
  localparam logic [31:0] Seed          = 32'h2b2d44da;
  localparam int          DirectWords   = 32;
  localparam int          DiffBankPairs = 8;
  localparam int          ConflictPairs = 6;
  localparam int          SameAddrPairs = 2;
  localparam int          RandCycles    = 400;
  localparam int          TotalReqs     = 4 * DirectWords + 2 * RandCycles +
                                          2 * (DiffBankPairs + ConflictPairs + SameAddrPairs);
  localparam int          WatchdogNs    = (TotalReqs * 4 + ResetCycles + 20) * ClkPeriodNs;

  logic                    clk;
  logic                    rst_n;
  logic                    host_req;
  host_domain_pkg::l2_op_e host_op;
  addr_t                   host_addr;
  data_t                   host_wdata;
  logic                    host_rsp;
  data_t                   host_rdata;
  logic                    udma_req;
  host_domain_pkg::l2_op_e udma_op;
  addr_t                   udma_addr;
  data_t                   udma_wdata;
  logic                    udma_rsp;
  data_t                   udma_rdata;

  data_t       ref_mem [host_domain_pkg::L2NumBanks * host_domain_pkg::L2BankWords];
  logic        host_wins [host_domain_pkg::L2NumBanks];
  exp_t        exp_q [2][$];
  logic [31:0] rng_state;
  int          neg_cnt;
  int          errors;
  int          checks;
  string       test_name;

  tb_clock_gen u_clk (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  host_domain u_dut (
    .clk_i        ( clk        ),
    .rst_n_i      ( rst_n      ),
    .host_req_i   ( host_req   ),
    .host_op_i    ( host_op    ),
    .host_addr_i  ( host_addr  ),
    .host_wdata_i ( host_wdata ),
    .host_rsp_o   ( host_rsp   ),
    .host_rdata_o ( host_rdata ),
    .udma_req_i   ( udma_req   ),
    .udma_op_i    ( udma_op    ),
    .udma_addr_i  ( udma_addr  ),
    .udma_wdata_i ( udma_wdata ),
    .udma_rsp_o   ( udma_rsp   ),
    .udma_rdata_o ( udma_rdata )
  );

  bind host_domain host_domain_checker u_checker (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .host_req_i ( host_req_i ),
    .udma_req_i ( udma_req_i ),
    .host_rsp_i ( host_rsp_o ),
    .udma_rsp_i ( udma_rsp_o )
  );

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Flat model memory where a write returns zero
  function automatic data_t ref_access(input host_domain_pkg::l2_op_e op, input addr_t addr,
                                       input data_t wdata);
    data_t rd;
    rd = '0;
    if (op == host_domain_pkg::L2_WRITE) begin
      ref_mem[addr] = wdata;
    end else begin
      rd = ref_mem[addr];
    end
    return rd;
  endfunction

  task automatic expect_rsp(input int m, input int due, input data_t data);
    exp_t e;
    e.due  = due;
    e.data = data;
    e.name = test_name;
    exp_q[m].push_back(e);
  endtask

  // One clock of stimulus; the model applies the winner first and the loser right after
  task automatic step(input logic h_req, input host_domain_pkg::l2_op_e h_op,
                      input addr_t h_addr, input data_t h_wd,
                      input logic u_req, input host_domain_pkg::l2_op_e u_op,
                      input addr_t u_addr, input data_t u_wd);
    logic [host_domain_pkg::L2BankSelWidth-1:0] bank;
    logic                                       conflict;
    logic                                       host_first;
    int                                         base;
    @(posedge clk);
    #DriveDelay;
    host_req   = h_req;
    host_op    = h_op;
    host_addr  = h_addr;
    host_wdata = h_wd;
    udma_req   = u_req;
    udma_op    = u_op;
    udma_addr  = u_addr;
    udma_wdata = u_wd;
    base       = neg_cnt;
    bank       = h_addr[host_domain_pkg::L2BankSelWidth-1:0];
    conflict   = h_req && u_req && (bank == u_addr[host_domain_pkg::L2BankSelWidth-1:0]);
    host_first = !conflict || host_wins[bank];
    if (conflict) begin
      host_wins[bank] = !host_wins[bank];
    end
    if (host_first) begin
      if (h_req) expect_rsp(0, base + 2, ref_access(h_op, h_addr, h_wd));
      if (u_req) expect_rsp(1, conflict ? base + 3 : base + 2, ref_access(u_op, u_addr, u_wd));
    end else begin
      expect_rsp(1, base + 2, ref_access(u_op, u_addr, u_wd));
      expect_rsp(0, base + 3, ref_access(h_op, h_addr, h_wd));
    end
  endtask

  task automatic idle();
    step(1'b0, host_domain_pkg::L2_READ, '0, '0, 1'b0, host_domain_pkg::L2_READ, '0, '0);
  endtask

  task automatic issue(input logic h_req, input host_domain_pkg::l2_op_e h_op,
                       input addr_t h_addr, input data_t h_wd,
                       input logic u_req, input host_domain_pkg::l2_op_e u_op,
                       input addr_t u_addr, input data_t u_wd);
    step(h_req, h_op, h_addr, h_wd, u_req, u_op, u_addr, u_wd);
    idle();
  endtask

  // Writes a block of words from one port, then reads it back
  task automatic single_port(input int m, input addr_t first);
    addr_t                   a;
    data_t                   d;
    host_domain_pkg::l2_op_e op;
    for (int p = 0; p < 2; p++) begin
      op = (p == 0) ? host_domain_pkg::L2_WRITE : host_domain_pkg::L2_READ;
      for (int i = 0; i < DirectWords; i++) begin
        a = first + addr_t'(i);
        d = next_random();
        if (m == 0) issue(1'b1, op, a, d, 1'b0, host_domain_pkg::L2_READ, '0, '0);
        else issue(1'b0, host_domain_pkg::L2_READ, '0, '0, 1'b1, op, a, d);
      end
    end
  endtask

  task automatic check_port(input int m, input logic rsp, input data_t rdata);
    exp_t  e;
    string who;
    who = (m == 0) ? "host" : "udma";
    if (rsp === 1'b1) begin
      if (exp_q[m].size() == 0) begin
        errors++;
        $display("ERROR: %s: %s response with no request outstanding", test_name, who);
      end else begin
        e = exp_q[m].pop_front();
        checks++;
        if (e.due != neg_cnt) begin
          errors++;
          $display("[FAIL] %s %s response cycle: expected %0d, actual %0d",
                   e.name, who, e.due, neg_cnt);
        end
        if (rdata !== e.data) begin
          errors++;
          $display("[FAIL] %s %s rdata: expected %h, actual %h", e.name, who, e.data, rdata);
        end
      end
    end else if (exp_q[m].size() != 0 && exp_q[m][0].due <= neg_cnt) begin
      errors++;
      $display("ERROR: %s: %s response missing at cycle %0d", exp_q[m][0].name, who, neg_cnt);
      exp_q[m].delete(0);
    end
  endtask

  // Outputs are registered, so the falling edge sees them settled
  always @(negedge clk) begin
    neg_cnt = neg_cnt + 1;
    check_port(0, host_rsp, host_rdata);
    check_port(1, udma_rsp, udma_rdata);
  end

  initial begin
    #(WatchdogNs);
    $display("ERROR: watchdog expired after %0d ns before the tests finished", WatchdogNs);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    logic [31:0]             r;
    logic                    h_go;
    logic                    u_go;
    logic                    h_last;
    logic                    u_last;
    host_domain_pkg::l2_op_e h_op;
    host_domain_pkg::l2_op_e u_op;
    host_req   = 1'b0;
    host_op    = host_domain_pkg::L2_READ;
    host_addr  = '0;
    host_wdata = '0;
    udma_req   = 1'b0;
    udma_op    = host_domain_pkg::L2_READ;
    udma_addr  = '0;
    udma_wdata = '0;
    neg_cnt    = 0;
    errors     = 0;
    checks     = 0;
    rng_state  = Seed;
    for (int b = 0; b < host_domain_pkg::L2NumBanks; b++) begin
      host_wins[b] = 1'b1;
    end
    wait (rst_n === 1'b1);

    test_name = "host_alone";
    single_port(0, addr_t'(0));
    test_name = "udma_alone";
    single_port(1, addr_t'(DirectWords));

    test_name = "diff_banks";
    for (int i = 0; i < DiffBankPairs; i++) begin
      issue(1'b1, host_domain_pkg::L2_WRITE, addr_t'(i), next_random(),
            1'b1, host_domain_pkg::L2_READ, addr_t'(8 * (4 + i % 4) + (i + 1) % 8), '0);
    end

    test_name = "bank_conflict";
    for (int i = 0; i < ConflictPairs; i++) begin
      issue(1'b1, host_domain_pkg::L2_WRITE, addr_t'(8 * (i % 4) + 3), next_random(),
            1'b1, host_domain_pkg::L2_READ, addr_t'(8 * (4 + i % 4) + 3), '0);
    end

    // First pass the read loses and sees new data, second pass it wins and sees old data
    test_name = "same_addr";
    for (int i = 0; i < SameAddrPairs; i++) begin
      issue(1'b1, host_domain_pkg::L2_WRITE, addr_t'(21), next_random(),
            1'b1, host_domain_pkg::L2_READ, addr_t'(21), '0);
    end

    test_name = "random_mixed";
    h_last = 1'b0;
    u_last = 1'b0;
    for (int i = 0; i < RandCycles; i++) begin
      r      = next_random();
      h_go   = !h_last && r[0];
      u_go   = !u_last && r[1];
      h_op   = r[14] ? host_domain_pkg::L2_WRITE : host_domain_pkg::L2_READ;
      u_op   = r[15] ? host_domain_pkg::L2_WRITE : host_domain_pkg::L2_READ;
      step(h_go, h_op, addr_t'(r[7:2]), next_random(), u_go, u_op, addr_t'(r[13:8]),
           next_random());
      h_last = h_go;
      u_last = u_go;
    end
    idle();

    for (int i = 0; i < 4 && (exp_q[0].size() + exp_q[1].size()) > 0; i++) begin
      @(negedge clk);
    end
    @(posedge clk);
    $display("Summary: %0d responses checked, %0d errors, %0d assertion failures",
             checks, errors, u_dut.u_checker.assert_fails);
    if (errors == 0 && u_dut.u_checker.assert_fails == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- verif/host_domain_checker.sv
// Bound into host_domain; the latency bound assumes one request per master every two clocks
module host_domain_checker (
  input logic clk_i,
  input logic rst_n_i,
  input logic host_req_i,
  input logic udma_req_i,
  input logic host_rsp_i,
  input logic udma_rsp_i
);

  timeunit 1ns;
  timeprecision 1ps;

  int assert_fails;

  host_rsp_follows_req: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) host_req_i |-> ##[1:2] host_rsp_i
  ) else begin
    assert_fails++;
    $error("host request not answered within two cycles");
  end

  udma_rsp_follows_req: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) udma_req_i |-> ##[1:2] udma_rsp_i
  ) else begin
    assert_fails++;
    $error("uDMA request not answered within two cycles");
  end

  rsp_known: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !$isunknown({host_rsp_i, udma_rsp_i})
  ) else begin
    assert_fails++;
    $error("response strobe unknown after reset");
  end

  // First cycle out of reset
  rsp_low_after_reset: assert property (
    @(posedge clk_i) $rose(rst_n_i) |-> !host_rsp_i && !udma_rsp_i
  ) else begin
    assert_fails++;
    $error("response strobe high in the first cycle after reset");
  end

endmodule

//--- verif/tb_clock_gen.sv
// Free-running 8 ns clock from time zero; reset is released 1 ns after the fifth rising edge
module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ClkPeriodNs = 8;
  localparam int ResetCycles = 5;

  initial begin
    clk_o = 1'b0;
    forever #(ClkPeriodNs / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

//--- design/host_domain.sv
// Shared L2 for two masters; each may request at most once every two clocks, no back-pressure
module host_domain (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,

  // Host port
  input  logic                                     host_req_i,
  input  host_domain_pkg::l2_op_e                  host_op_i,
  input  logic [host_domain_pkg::L2AddrWidth-1:0]  host_addr_i,
  input  logic [host_domain_pkg::L2DataWidth-1:0]  host_wdata_i,
  output logic                                     host_rsp_o,
  output logic [host_domain_pkg::L2DataWidth-1:0]  host_rdata_o,

  // uDMA port
  input  logic                                     udma_req_i,
  input  host_domain_pkg::l2_op_e                  udma_op_i,
  input  logic [host_domain_pkg::L2AddrWidth-1:0]  udma_addr_i,
  input  logic [host_domain_pkg::L2DataWidth-1:0]  udma_wdata_i,
  output logic                                     udma_rsp_o,
  output logic [host_domain_pkg::L2DataWidth-1:0]  udma_rdata_o
);

  logic                                    host_valid;
  host_domain_pkg::l2_op_e                 host_op;
  logic [host_domain_pkg::L2AddrWidth-1:0] host_addr;
  logic [host_domain_pkg::L2DataWidth-1:0] host_wdata;
  logic                                    host_gnt;

  logic                                    udma_valid;
  host_domain_pkg::l2_op_e                 udma_op;
  logic [host_domain_pkg::L2AddrWidth-1:0] udma_addr;
  logic [host_domain_pkg::L2DataWidth-1:0] udma_wdata;
  logic                                    udma_gnt;

  // Merged per-bank accesses
  logic [host_domain_pkg::L2NumBanks-1:0]                                   bank_en;
  logic [host_domain_pkg::L2NumBanks-1:0]                                   bank_we;
  logic [host_domain_pkg::L2NumBanks-1:0][host_domain_pkg::L2RowWidth-1:0]  bank_row;
  logic [host_domain_pkg::L2NumBanks-1:0][host_domain_pkg::L2DataWidth-1:0] bank_wdata;
  host_domain_pkg::l2_master_e [host_domain_pkg::L2NumBanks-1:0]            bank_tag;

  l2_req_buffer u_host_buf (
    .clk_i   ( clk_i        ),
    .rst_n_i ( rst_n_i      ),
    .req_i   ( host_req_i   ),
    .op_i    ( host_op_i    ),
    .addr_i  ( host_addr_i  ),
    .wdata_i ( host_wdata_i ),
    .gnt_i   ( host_gnt     ),
    .valid_o ( host_valid   ),
    .op_o    ( host_op      ),
    .addr_o  ( host_addr    ),
    .wdata_o ( host_wdata   )
  );

  l2_req_buffer u_udma_buf (
    .clk_i   ( clk_i        ),
    .rst_n_i ( rst_n_i      ),
    .req_i   ( udma_req_i   ),
    .op_i    ( udma_op_i    ),
    .addr_i  ( udma_addr_i  ),
    .wdata_i ( udma_wdata_i ),
    .gnt_i   ( udma_gnt     ),
    .valid_o ( udma_valid   ),
    .op_o    ( udma_op      ),
    .addr_o  ( udma_addr    ),
    .wdata_o ( udma_wdata   )
  );

  l2_bank_arbiter u_arbiter (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .host_valid_i ( host_valid ),
    .host_op_i    ( host_op    ),
    .host_addr_i  ( host_addr  ),
    .host_wdata_i ( host_wdata ),
    .udma_valid_i ( udma_valid ),
    .udma_op_i    ( udma_op    ),
    .udma_addr_i  ( udma_addr  ),
    .udma_wdata_i ( udma_wdata ),
    .host_gnt_o   ( host_gnt   ),
    .udma_gnt_o   ( udma_gnt   ),
    .bank_en_o    ( bank_en    ),
    .bank_we_o    ( bank_we    ),
    .row_o        ( bank_row   ),
    .wdata_o      ( bank_wdata ),
    .tag_o        ( bank_tag   )
  );

  l2_bank_array u_banks (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .bank_en_i    ( bank_en      ),
    .bank_we_i    ( bank_we      ),
    .row_i        ( bank_row     ),
    .wdata_i      ( bank_wdata   ),
    .tag_i        ( bank_tag     ),
    .host_rsp_o   ( host_rsp_o   ),
    .host_rdata_o ( host_rdata_o ),
    .udma_rsp_o   ( udma_rsp_o   ),
    .udma_rdata_o ( udma_rdata_o )
  );

endmodule

//--- design/l2_bank_array.sv
// At most one access per bank per cycle and one bank per master; write responses return zero
module l2_bank_array (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,

  input  logic [host_domain_pkg::L2NumBanks-1:0]       bank_en_i,
  input  logic [host_domain_pkg::L2NumBanks-1:0]       bank_we_i,
  input  logic [host_domain_pkg::L2NumBanks-1:0][host_domain_pkg::L2RowWidth-1:0]  row_i,
  input  logic [host_domain_pkg::L2NumBanks-1:0][host_domain_pkg::L2DataWidth-1:0] wdata_i,
  input  host_domain_pkg::l2_master_e [host_domain_pkg::L2NumBanks-1:0]            tag_i,

  output logic                                         host_rsp_o,
  output logic [host_domain_pkg::L2DataWidth-1:0]      host_rdata_o,
  output logic                                         udma_rsp_o,
  output logic [host_domain_pkg::L2DataWidth-1:0]      udma_rdata_o
);

  // Per-bank response stage
  logic                                    rsp_q   [host_domain_pkg::L2NumBanks];
  logic [host_domain_pkg::L2DataWidth-1:0] rdata_q [host_domain_pkg::L2NumBanks];
  host_domain_pkg::l2_master_e             tag_q   [host_domain_pkg::L2NumBanks];

  for (genvar b = 0; b < host_domain_pkg::L2NumBanks; b++) begin : g_bank
    logic [host_domain_pkg::L2DataWidth-1:0] mem_q [host_domain_pkg::L2BankWords];

    always_ff @(posedge clk_i) begin
      if (bank_en_i[b]) begin
        if (bank_we_i[b]) begin
          mem_q[row_i[b]] <= wdata_i[b];
          rdata_q[b]      <= '0;
        end else begin
          rdata_q[b] <= mem_q[row_i[b]];
        end
        tag_q[b] <= tag_i[b];
      end
    end

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        rsp_q[b] <= 1'b0;
      end else begin
        rsp_q[b] <= bank_en_i[b];
      end
    end
  end

  // Route each bank response to the master that owns it
  always_comb begin
    host_rsp_o   = 1'b0;
    host_rdata_o = '0;
    udma_rsp_o   = 1'b0;
    udma_rdata_o = '0;
    for (int b = 0; b < host_domain_pkg::L2NumBanks; b++) begin
      if (rsp_q[b]) begin
        if (tag_q[b] == host_domain_pkg::MASTER_HOST) begin
          host_rsp_o   = 1'b1;
          host_rdata_o = rdata_q[b];
        end else begin
          udma_rsp_o   = 1'b1;
          udma_rdata_o = rdata_q[b];
        end
      end
    end
  end

endmodule

//--- design/l2_bank_arbiter.sv
// Two masters only; a loser is granted next cycle because the winner cannot request again yet
module l2_bank_arbiter (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,

  input  logic                                         host_valid_i,
  input  host_domain_pkg::l2_op_e                      host_op_i,
  input  logic [host_domain_pkg::L2AddrWidth-1:0]      host_addr_i,
  input  logic [host_domain_pkg::L2DataWidth-1:0]      host_wdata_i,

  input  logic                                         udma_valid_i,
  input  host_domain_pkg::l2_op_e                      udma_op_i,
  input  logic [host_domain_pkg::L2AddrWidth-1:0]      udma_addr_i,
  input  logic [host_domain_pkg::L2DataWidth-1:0]      udma_wdata_i,

  output logic                                         host_gnt_o,
  output logic                                         udma_gnt_o,

  output logic [host_domain_pkg::L2NumBanks-1:0]       bank_en_o,
  output logic [host_domain_pkg::L2NumBanks-1:0]       bank_we_o,
  output logic [host_domain_pkg::L2NumBanks-1:0][host_domain_pkg::L2RowWidth-1:0]  row_o,
  output logic [host_domain_pkg::L2NumBanks-1:0][host_domain_pkg::L2DataWidth-1:0] wdata_o,
  output host_domain_pkg::l2_master_e [host_domain_pkg::L2NumBanks-1:0]            tag_o
);

  logic [host_domain_pkg::L2BankSelWidth-1:0] host_bank;
  logic [host_domain_pkg::L2BankSelWidth-1:0] udma_bank;
  logic [host_domain_pkg::L2RowWidth-1:0]     host_row;
  logic [host_domain_pkg::L2RowWidth-1:0]     udma_row;
  logic                                       conflict;
  logic [host_domain_pkg::L2NumBanks-1:0]     host_sel;
  logic [host_domain_pkg::L2NumBanks-1:0]     udma_sel;

  // Master that wins the next conflict on each bank
  host_domain_pkg::l2_master_e [host_domain_pkg::L2NumBanks-1:0] rr_q;

  assign host_bank = host_addr_i[host_domain_pkg::L2BankSelWidth-1:0];
  assign udma_bank = udma_addr_i[host_domain_pkg::L2BankSelWidth-1:0];
  assign host_row  = host_addr_i[host_domain_pkg::L2AddrWidth-1:host_domain_pkg::L2BankSelWidth];
  assign udma_row  = udma_addr_i[host_domain_pkg::L2AddrWidth-1:host_domain_pkg::L2BankSelWidth];

  assign conflict = host_valid_i && udma_valid_i && (host_bank == udma_bank);

  assign host_gnt_o = host_valid_i &&
                      (!conflict || (rr_q[host_bank] == host_domain_pkg::MASTER_HOST));
  assign udma_gnt_o = udma_valid_i &&
                      (!conflict || (rr_q[udma_bank] == host_domain_pkg::MASTER_UDMA));

  // One-hot bank selects of the granted accesses
  always_comb begin
    host_sel = '0;
    udma_sel = '0;
    host_sel[host_bank] = host_gnt_o;
    udma_sel[udma_bank] = udma_gnt_o;
  end

  always_comb begin
    for (int b = 0; b < host_domain_pkg::L2NumBanks; b++) begin
      bank_en_o[b] = 1'b0;
      bank_we_o[b] = 1'b0;
      row_o[b]     = '0;
      wdata_o[b]   = '0;
      tag_o[b]     = host_domain_pkg::MASTER_HOST;
      if (host_sel[b]) begin
        bank_en_o[b] = 1'b1;
        bank_we_o[b] = (host_op_i == host_domain_pkg::L2_WRITE);
        row_o[b]     = host_row;
        wdata_o[b]   = host_wdata_i;
        tag_o[b]     = host_domain_pkg::MASTER_HOST;
      end else if (udma_sel[b]) begin
        bank_en_o[b] = 1'b1;
        bank_we_o[b] = (udma_op_i == host_domain_pkg::L2_WRITE);
        row_o[b]     = udma_row;
        wdata_o[b]   = udma_wdata_i;
        tag_o[b]     = host_domain_pkg::MASTER_UDMA;
      end
    end
  end

  // Priority flips only on a bank that saw a conflict
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int b = 0; b < host_domain_pkg::L2NumBanks; b++) begin
        rr_q[b] <= host_domain_pkg::MASTER_HOST;
      end
    end else if (conflict) begin
      rr_q[host_bank] <= host_gnt_o ? host_domain_pkg::MASTER_UDMA
                                    : host_domain_pkg::MASTER_HOST;
    end
  end

endmodule

//--- design/l2_req_buffer.sv
// One-deep slot; relies on the master issuing at most one request every two clocks
module l2_req_buffer (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  logic                                     req_i,
  input  host_domain_pkg::l2_op_e                  op_i,
  input  logic [host_domain_pkg::L2AddrWidth-1:0]  addr_i,
  input  logic [host_domain_pkg::L2DataWidth-1:0]  wdata_i,
  input  logic                                     gnt_i,
  output logic                                     valid_o,
  output host_domain_pkg::l2_op_e                  op_o,
  output logic [host_domain_pkg::L2AddrWidth-1:0]  addr_o,
  output logic [host_domain_pkg::L2DataWidth-1:0]  wdata_o
);

  logic                                    pend_q;
  host_domain_pkg::l2_op_e                 pend_op_q;
  logic [host_domain_pkg::L2AddrWidth-1:0] pend_addr_q;
  logic [host_domain_pkg::L2DataWidth-1:0] pend_wdata_q;

  // Held request has priority over the live inputs
  assign valid_o = pend_q | req_i;
  assign op_o    = pend_q ? pend_op_q    : op_i;
  assign addr_o  = pend_q ? pend_addr_q  : addr_i;
  assign wdata_o = pend_q ? pend_wdata_q : wdata_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pend_q <= 1'b0;
    end else if (pend_q) begin
      if (gnt_i) begin
        pend_q <= 1'b0;
      end
    end else if (req_i && !gnt_i) begin
      pend_q <= 1'b1;
    end
  end

  // Payload captured only when a live request loses
  always_ff @(posedge clk_i) begin
    if (!pend_q && req_i && !gnt_i) begin
      pend_op_q    <= op_i;
      pend_addr_q  <= addr_i;
      pend_wdata_q <= wdata_i;
    end
  end

endmodule

//--- design/host_domain_pkg.sv
// Bank count and depth are fixed here; the address interleaves banks on its low bits
package host_domain_pkg;

  // Memory geometry
  localparam int unsigned L2NumBanks  = 8;
  localparam int unsigned L2BankWords = 256;
  localparam int unsigned L2DataWidth = 32;

  localparam int unsigned L2BankSelWidth = $clog2(L2NumBanks);
  localparam int unsigned L2RowWidth     = $clog2(L2BankWords);

  // Low bits pick the bank, high bits pick the row
  localparam int unsigned L2AddrWidth = L2BankSelWidth + L2RowWidth;

  // Access type carried with every request
  typedef enum logic [0:0] {
    L2_READ  = 1'b0,
    L2_WRITE = 1'b1
  } l2_op_e;

  // Master identity, used as round-robin state and response tag
  typedef enum logic [0:0] {
    MASTER_HOST = 1'b0,
    MASTER_UDMA = 1'b1
  } l2_master_e;

endpackage
